//--- rtl/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // instruction formats, most significant field first
    typedef struct packed {
        logic [16:0] op;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_3r_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] i12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_2ri12_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] i20;
        reg_idx_t    rd;
    } inst_1ri20_t;

    // 3R group, opcode bits 31:15
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;
    // immediate shifts share the 3R layout, ui5 sits in the rk slot
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;

    // 2RI12 group, opcode bits 31:22
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_SLTIU  = 10'h009;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;

    // 1RI20 group, opcode bits 31:25
    localparam logic [6:0] OP_LU12I_W    = 7'h0a;
    localparam logic [6:0] OP_PCADDU12I  = 7'h0e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        reg_idx_t    rj;
        reg_idx_t    rk;
        reg_idx_t    dest;
        logic        use_rj;
        logic        use_rk;
        logic        src1_pc;
        logic        src2_imm;
        logic [31:0] imm;
        logic        we;
    } decoded_t;

endpackage

//--- rtl/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    typedef logic [31:0] word_t;

    // first fetch address after reset
    localparam word_t RESET_PC = 32'h1c00_0000;

    localparam int QUEUE_DEPTH = 2;
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [COUNT_W-1:0] count_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t wnum;
        word_t    wdata;
    } trace_t;

endpackage

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    output logic   inst_sram_req,
    output word_t  inst_sram_addr,
    input  logic   inst_sram_addr_ok,
    input  logic   inst_sram_data_ok,
    input  word_t  inst_sram_rdata,
    input  count_t count,
    output logic   push,
    output fetch_t push_data
);

    word_t pc;
    word_t req_pc;
    logic  outstanding;
    logic  fetch_en;
    logic  room;
    logic  accept;

    // the word in flight holds a queue slot until it is pushed
    assign room = int'(count) + int'(outstanding) < QUEUE_DEPTH;

    // a new address may go out in the cycle the previous word returns
    assign inst_sram_req  = fetch_en && (!outstanding || inst_sram_data_ok) && room;
    assign inst_sram_addr = pc;
    assign accept         = inst_sram_req && inst_sram_addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en    <= 1'b0;
            outstanding <= 1'b0;
            pc          <= RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            if (accept) begin
                outstanding <= 1'b1;
                pc          <= pc + 32'd4;
            end else if (inst_sram_data_ok) begin
                outstanding <= 1'b0;
            end
        end
    end

    // pc of the accepted address, paired with its returning word
    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc <= pc;
        end
    end

    assign push           = outstanding && inst_sram_data_ok;
    assign push_data.pc   = req_pc;
    assign push_data.inst = inst_sram_rdata;

endmodule

//--- rtl/inst_queue.sv
`timescale 1ns/100ps

module inst_queue
    import pipe_pkg::*;
#(
    parameter type payload_t = logic [31:0]
)(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     valid,
    output count_t   count
);

    payload_t mem [QUEUE_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    logic     do_pop;

    // wrap also for depths that are not a power of two
    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign valid  = count != '0;
    assign head   = mem[rd_ptr];
    assign do_pop = pop && valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- rtl/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t    inst,
    output decoded_t dec
);

    inst_3r_t    f3r;
    inst_2ri12_t f12;
    inst_1ri20_t f20;
    logic        is_3r;
    logic        is_sh;
    logic        is_i12;
    logic        is_si12;
    logic        is_lu12i;
    logic        is_pcadd;

    assign f3r = inst;
    assign f12 = inst;
    assign f20 = inst;

    assign is_3r = f3r.op inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
                                  OP_OR, OP_XOR, OP_SLL_W, OP_SRL_W, OP_SRA_W};
    assign is_sh = f3r.op inside {OP_SLLI_W, OP_SRLI_W, OP_SRAI_W};
    assign is_i12 = f12.op inside {OP_SLTI, OP_SLTIU, OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI};
    // slti and sltiu sign-extend too
    assign is_si12 = f12.op inside {OP_SLTI, OP_SLTIU, OP_ADDI_W};
    assign is_lu12i = f20.op == OP_LU12I_W;
    assign is_pcadd = f20.op == OP_PCADDU12I;

    always_comb begin
        dec      = '0;
        dec.rj   = f3r.rj;
        dec.rk   = f3r.rk;
        dec.dest = f3r.rd;

        // the three opcode groups never overlap
        case (f3r.op)
            OP_SUB_W:  dec.alu_op = ALU_SUB;
            OP_SLT:    dec.alu_op = ALU_SLT;
            OP_SLTU:   dec.alu_op = ALU_SLTU;
            OP_NOR:    dec.alu_op = ALU_NOR;
            OP_AND:    dec.alu_op = ALU_AND;
            OP_OR:     dec.alu_op = ALU_OR;
            OP_XOR:    dec.alu_op = ALU_XOR;
            OP_SLL_W:  dec.alu_op = ALU_SLL;
            OP_SLLI_W: dec.alu_op = ALU_SLL;
            OP_SRL_W:  dec.alu_op = ALU_SRL;
            OP_SRLI_W: dec.alu_op = ALU_SRL;
            OP_SRA_W:  dec.alu_op = ALU_SRA;
            OP_SRAI_W: dec.alu_op = ALU_SRA;
            default:   ;
        endcase
        case (f12.op)
            OP_SLTI:  dec.alu_op = ALU_SLT;
            OP_SLTIU: dec.alu_op = ALU_SLTU;
            OP_ANDI:  dec.alu_op = ALU_AND;
            OP_ORI:   dec.alu_op = ALU_OR;
            OP_XORI:  dec.alu_op = ALU_XOR;
            default:  ;
        endcase
        if (is_lu12i) begin
            dec.alu_op = ALU_LUI;
        end

        // add.w, addi.w and pcaddu12i keep the default add
        if (is_sh) begin
            dec.imm = {27'b0, f3r.rk};
        end else if (is_si12) begin
            dec.imm = {{20{f12.i12[11]}}, f12.i12};
        end else if (is_i12) begin
            dec.imm = {20'b0, f12.i12};
        end else begin
            dec.imm = {f20.i20, 12'b0};
        end

        dec.use_rj   = is_3r || is_sh || is_i12;
        dec.use_rk   = is_3r;
        dec.src1_pc  = is_pcadd;
        dec.src2_imm = is_sh || is_i12 || is_lu12i || is_pcadd;
        // anything outside the subset retires without a write
        dec.we       = is_3r || is_sh || is_i12 || is_lu12i || is_pcadd;
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps

module alu
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  alu_op_t op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = word_t'($signed(src1) >>> shamt);
            // lu12i.w passes the shifted immediate
            ALU_LUI:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

//--- rtl/exec_pipe.sv
`timescale 1ns/100ps

module exec_pipe
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  fetch_t head,
    input  logic   valid,
    output logic   pop,
    output trace_t trace
);

    decoded_t dec;
    word_t    rf [32];
    word_t    rj_val;
    word_t    rk_val;
    word_t    src1;
    word_t    src2;
    word_t    result;
    logic     fwd_rj;
    logic     fwd_rk;
    logic     wr_en;

    inst_decoder u_dec (
        .inst (head.inst),
        .dec  (dec)
    );

    // no stall source, every valid head is consumed
    assign pop = valid;

    // trace holds the writeback stage; its we is never set for r0
    assign fwd_rj = trace.we && dec.use_rj && (trace.wnum == dec.rj);
    assign fwd_rk = trace.we && dec.use_rk && (trace.wnum == dec.rk);

    always_comb begin
        if (dec.rj == '0) begin
            rj_val = '0;
        end else if (fwd_rj) begin
            rj_val = trace.wdata;
        end else begin
            rj_val = rf[dec.rj];
        end
        if (dec.rk == '0) begin
            rk_val = '0;
        end else if (fwd_rk) begin
            rk_val = trace.wdata;
        end else begin
            rk_val = rf[dec.rk];
        end
    end

    assign src1 = dec.src1_pc ? head.pc : rj_val;
    assign src2 = dec.src2_imm ? dec.imm : rk_val;

    alu u_alu (
        .op     (dec.alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (result)
    );

    assign wr_en = valid && dec.we && (dec.dest != '0);

    // writeback register, only the write enable is cleared
    always_ff @(posedge clk) begin
        if (valid) begin
            trace.pc    <= head.pc;
            trace.wnum  <= dec.dest;
            trace.wdata <= result;
        end
        if (reset) begin
            trace.we <= 1'b0;
        end else begin
            trace.we <= wr_en;
        end
    end

    // register file updated at the end of the trace cycle
    always_ff @(posedge clk) begin
        if (trace.we) begin
            rf[trace.wnum] <= trace.wdata;
        end
    end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/100ps

module core_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    output logic     inst_sram_req,
    output word_t    inst_sram_addr,
    input  logic     inst_sram_addr_ok,
    input  logic     inst_sram_data_ok,
    input  word_t    inst_sram_rdata,
    output word_t    debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t debug_wb_rf_wnum,
    output word_t    debug_wb_rf_wdata
);

    count_t count;
    logic   push;
    fetch_t push_data;
    fetch_t head;
    logic   valid;
    logic   pop;
    trace_t trace;

    fetch_unit u_fetch (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .count             (count),
        .push              (push),
        .push_data         (push_data)
    );

    inst_queue #(
        .payload_t (fetch_t)
    ) u_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .valid     (valid),
        .count     (count)
    );

    exec_pipe u_exec (
        .clk   (clk),
        .reset (reset),
        .head  (head),
        .valid (valid),
        .pop   (pop),
        .trace (trace)
    );

    // debug trace, write enable repeated per byte lane
    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_we    = {4{trace.we}};
    assign debug_wb_rf_wnum  = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

endmodule

//--- bench/core_chk.sv
`timescale 1ns/100ps

module core_chk
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       inst_sram_req,
    input word_t      inst_sram_addr,
    input logic       inst_sram_addr_ok,
    input logic       inst_sram_data_ok,
    input word_t      debug_wb_pc,
    input logic [3:0] debug_wb_rf_we,
    input reg_idx_t   debug_wb_rf_wnum
);

    logic  pending;
    logic  seen_write;
    word_t last_pc;
    int    fail_count = 0;

    // own view of the outstanding request and the last retired pc
    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= 1'b0;
            seen_write <= 1'b0;
            last_pc    <= '0;
        end else begin
            if (inst_sram_req && inst_sram_addr_ok) begin
                pending <= 1'b1;
            end else if (inst_sram_data_ok) begin
                pending <= 1'b0;
            end
            if (debug_wb_rf_we[0]) begin
                seen_write <= 1'b1;
                last_pc    <= debug_wb_pc;
            end
        end
    end

    no_req_in_reset: assert property (@(posedge clk) reset |-> inst_sram_req !== 1'b1)
        else begin
            $error("instruction request raised during reset");
            fail_count++;
        end

    // address phase holds until accepted
    req_held: assert property (@(posedge clk) disable iff (reset)
        inst_sram_req && !inst_sram_addr_ok |=> inst_sram_req && $stable(inst_sram_addr))
        else begin
            $error("request dropped or address changed before addr_ok");
            fail_count++;
        end

    // a new request may only overlap the cycle its predecessor returns
    no_second_req: assert property (@(posedge clk) disable iff (reset)
        pending && !inst_sram_data_ok |-> !inst_sram_req)
        else begin
            $error("request raised while another one is outstanding");
            fail_count++;
        end

    no_r0_write: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we[0] |-> debug_wb_rf_wnum != '0)
        else begin
            $error("trace write enable set for register 0");
            fail_count++;
        end

    trace_pc_order: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we[0] |->
            debug_wb_pc[1:0] == 2'b00 && (!seen_write || debug_wb_pc > last_pc))
        else begin
            $error("trace pc misaligned or out of program order");
            fail_count++;
        end

endmodule

bind core_top core_chk i_chk (
    .clk               (clk),
    .reset             (reset),
    .inst_sram_req     (inst_sram_req),
    .inst_sram_addr    (inst_sram_addr),
    .inst_sram_addr_ok (inst_sram_addr_ok),
    .inst_sram_data_ok (inst_sram_data_ok),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_we    (debug_wb_rf_we),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum)
);

//--- bench/tb_core.sv
`timescale 1ns/100ps

module tb_core
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int PROG_LEN       = 40;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 10 + 100;
    localparam int NUM_TESTS      = 6;
    localparam int T_RESET        = 0;
    localparam int T_IMM          = 1;
    localparam int T_UPPER        = 2;
    localparam int T_CHAIN        = 3;
    localparam int T_ZERO         = 4;
    localparam int T_ORDER        = 5;

    // one predicted register write
    typedef struct packed {
        word_t      pc;
        reg_idx_t   rd;
        word_t      value;
        logic [2:0] tid;
    } expect_t;

    logic       clk;
    logic       reset;
    logic       inst_sram_req;
    word_t      inst_sram_addr;
    logic       inst_sram_addr_ok;
    logic       inst_sram_data_ok;
    word_t      inst_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    integer  seed;
    word_t   prog [PROG_LEN];
    int      prog_len;
    word_t   gold [32];
    expect_t expq [$];
    int      remaining [NUM_TESTS];
    int      err_count [NUM_TESTS];
    bit      reported [NUM_TESTS];
    string   test_name [NUM_TESTS];
    bit      first_data;
    int      cycle_count;
    int      passed;
    int      failed;

    // SRAM model state
    bit      pending;
    word_t   pend_addr;
    int      addr_wait;
    int      data_wait;
    // addresses served with zero latency
    word_t   fast_lo;
    word_t   fast_hi;

    core_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int draw_delay();
        logic [31:0] r;
        r = $random(seed);
        return int'(r[1:0]);
    endfunction

    // words past the program read as zero, an unknown encoding
    function automatic word_t fetch_word(word_t addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if (addr >= RESET_PC && idx < prog_len) begin
            return prog[idx];
        end else begin
            return '0;
        end
    endfunction

    function automatic word_t next_pc();
        return RESET_PC + word_t'(prog_len * 4);
    endfunction

    function automatic word_t ref_reg_op(logic [16:0] op, word_t a, word_t b);
        case (op)
            OP_ADD_W:             return a + b;
            OP_SUB_W:             return a - b;
            OP_SLT:               return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:              return (a < b) ? 32'd1 : 32'd0;
            OP_NOR:               return ~(a | b);
            OP_AND:               return a & b;
            OP_OR:                return a | b;
            OP_XOR:               return a ^ b;
            OP_SLL_W, OP_SLLI_W:  return a << b[4:0];
            OP_SRL_W, OP_SRLI_W:  return a >> b[4:0];
            OP_SRA_W, OP_SRAI_W:  return word_t'($signed(a) >>> b[4:0]);
            default:              return '0;
        endcase
    endfunction

    function automatic word_t ref_imm_op(logic [9:0] op, word_t a, logic [11:0] i12);
        word_t sx;
        word_t zx;
        sx = {{20{i12[11]}}, i12};
        zx = {20'b0, i12};
        case (op)
            OP_ADDI_W: return a + sx;
            OP_SLTI:   return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_SLTIU:  return (a < sx) ? 32'd1 : 32'd0;
            OP_ANDI:   return a & zx;
            OP_ORI:    return a | zx;
            OP_XORI:   return a ^ zx;
            default:   return '0;
        endcase
    endfunction

    // appends one word and, for a real write, its prediction
    task automatic place_inst(word_t enc, int rd, word_t value, bit writes, int tid);
        expect_t e;
        e.pc  = next_pc();
        e.rd  = reg_idx_t'(rd);
        e.value = value;
        e.tid = 3'(tid);
        prog[prog_len] = enc;
        prog_len++;
        if (writes && rd != 0) begin
            gold[rd] = value;
            expq.push_back(e);
            remaining[tid]++;
        end
    endtask

    task automatic rr_inst(logic [16:0] op, int rd, int rj, int rk, int tid);
        place_inst({op, reg_idx_t'(rk), reg_idx_t'(rj), reg_idx_t'(rd)}, rd,
                   ref_reg_op(op, gold[rj], gold[rk]), 1'b1, tid);
    endtask

    task automatic shift_inst(logic [16:0] op, int rd, int rj, logic [4:0] ui5, int tid);
        place_inst({op, ui5, reg_idx_t'(rj), reg_idx_t'(rd)}, rd,
                   ref_reg_op(op, gold[rj], {27'b0, ui5}), 1'b1, tid);
    endtask

    task automatic imm_inst(logic [9:0] op, int rd, int rj, logic [11:0] i12, int tid);
        place_inst({op, i12, reg_idx_t'(rj), reg_idx_t'(rd)}, rd,
                   ref_imm_op(op, gold[rj], i12), 1'b1, tid);
    endtask

    task automatic upper_inst(logic [6:0] op, int rd, logic [19:0] i20, int tid);
        word_t value;
        value = {i20, 12'b0};
        if (op == OP_PCADDU12I) begin
            value = value + next_pc();
        end
        place_inst({op, i20, reg_idx_t'(rd)}, rd, value, 1'b1, tid);
    endtask

    task automatic unknown_inst(word_t enc, int tid);
        place_inst(enc, 0, '0, 1'b0, tid);
    endtask

    task automatic load_program();
        imm_inst(OP_ADDI_W, 1, 0, 12'h123, T_IMM);
        imm_inst(OP_ADDI_W, 2, 0, 12'hffb, T_IMM);
        imm_inst(OP_ADDI_W, 3, 2, 12'h800, T_IMM);
        imm_inst(OP_SLTI, 4, 2, 12'h001, T_IMM);
        imm_inst(OP_SLTI, 5, 1, 12'hfff, T_IMM);
        imm_inst(OP_SLTIU, 6, 1, 12'hfff, T_IMM);
        imm_inst(OP_SLTIU, 7, 2, 12'h003, T_IMM);
        imm_inst(OP_ANDI, 8, 2, 12'hf0f, T_IMM);
        imm_inst(OP_ORI, 9, 1, 12'h800, T_IMM);
        imm_inst(OP_XORI, 10, 2, 12'hfff, T_IMM);
        shift_inst(OP_SLLI_W, 11, 2, 5'd0, T_IMM);
        shift_inst(OP_SLLI_W, 12, 1, 5'd31, T_IMM);
        shift_inst(OP_SRLI_W, 13, 2, 5'd31, T_IMM);
        shift_inst(OP_SRAI_W, 14, 2, 5'd31, T_IMM);
        shift_inst(OP_SRAI_W, 15, 3, 5'd4, T_IMM);
        shift_inst(OP_SRLI_W, 16, 3, 5'd0, T_IMM);
        upper_inst(OP_LU12I_W, 17, 20'h12345, T_UPPER);
        upper_inst(OP_LU12I_W, 18, 20'h80000, T_UPPER);
        upper_inst(OP_PCADDU12I, 19, 20'h00001, T_UPPER);
        upper_inst(OP_PCADDU12I, 20, 20'hfffff, T_UPPER);
        imm_inst(OP_ORI, 17, 17, 12'h678, T_UPPER);
        // each result feeds the next and arrives back to back, which exercises forwarding
        fast_lo = next_pc();
        rr_inst(OP_ADD_W, 21, 17, 1, T_CHAIN);
        rr_inst(OP_SUB_W, 21, 21, 2, T_CHAIN);
        rr_inst(OP_XOR, 22, 21, 18, T_CHAIN);
        rr_inst(OP_OR, 22, 22, 9, T_CHAIN);
        rr_inst(OP_AND, 23, 22, 17, T_CHAIN);
        rr_inst(OP_NOR, 24, 23, 2, T_CHAIN);
        rr_inst(OP_SLL_W, 25, 24, 1, T_CHAIN);
        rr_inst(OP_SRL_W, 25, 25, 13, T_CHAIN);
        rr_inst(OP_SRA_W, 26, 25, 20, T_CHAIN);
        rr_inst(OP_SLT, 27, 26, 25, T_CHAIN);
        rr_inst(OP_SLTU, 28, 27, 26, T_CHAIN);
        rr_inst(OP_ADD_W, 29, 28, 28, T_CHAIN);
        rr_inst(OP_SUB_W, 30, 29, 17, T_CHAIN);
        fast_hi = next_pc();
        imm_inst(OP_ADDI_W, 0, 1, 12'h005, T_ZERO);
        rr_inst(OP_ADD_W, 0, 17, 18, T_ZERO);
        rr_inst(OP_ADD_W, 5, 0, 1, T_ZERO);
        unknown_inst(32'hffff_ffff, T_ZERO);
        imm_inst(OP_ADDI_W, 6, 5, 12'h001, T_ZERO);
        rr_inst(OP_OR, 7, 0, 0, T_ZERO);
    endtask

    task automatic note_failure(int tid, string msg);
        $display("ERROR %s: %s", test_name[tid], msg);
        err_count[tid]++;
    endtask

    task automatic note_mismatch(int tid, string what, word_t expected, word_t actual);
        $display("FAIL %s %s: expected %h, actual %h", test_name[tid], what, expected, actual);
        err_count[tid]++;
    endtask

    task automatic report_test(int tid);
        if (!reported[tid]) begin
            reported[tid] = 1'b1;
            if (err_count[tid] == 0) begin
                $display("test %0d %s: passed", tid, test_name[tid]);
            end else begin
                $display("test %0d %s: failed, %0d errors", tid, test_name[tid], err_count[tid]);
            end
        end
    endtask

    task automatic check_write();
        expect_t e;
        assert (expq.size() != 0)
            else note_failure(T_ORDER, $sformatf("unexpected trace write at pc %h", debug_wb_pc));
        if (expq.size() != 0) begin
            e = expq.pop_front();
            assert (debug_wb_rf_we == 4'hf)
                else note_failure(int'(e.tid), "write enable copies disagree");
            assert (debug_wb_pc == e.pc)
                else note_mismatch(int'(e.tid), "pc", e.pc, debug_wb_pc);
            assert (debug_wb_rf_wnum == e.rd)
                else note_mismatch(int'(e.tid), "wnum", word_t'(e.rd), word_t'(debug_wb_rf_wnum));
            assert (debug_wb_rf_wdata == e.value)
                else note_mismatch(int'(e.tid), "wdata", e.value, debug_wb_rf_wdata);
            remaining[e.tid]--;
            if (remaining[e.tid] == 0) begin
                report_test(int'(e.tid));
            end
        end
    endtask

    // instruction SRAM with random address and data latency
    always @(posedge clk) begin
        #1;
        inst_sram_data_ok = 1'b0;
        if (pending) begin
            if (data_wait == 0) begin
                inst_sram_data_ok = 1'b1;
                inst_sram_rdata   = fetch_word(pend_addr);
                pending           = 1'b0;
            end else begin
                data_wait--;
            end
        end
        inst_sram_addr_ok = (addr_wait == 0);
    end

    // address handshake, taken once req has settled
    always @(negedge clk) begin
        if (inst_sram_req) begin
            if (inst_sram_addr_ok) begin
                pending   = 1'b1;
                pend_addr = inst_sram_addr;
                if (inst_sram_addr >= fast_lo && inst_sram_addr < fast_hi) begin
                    data_wait = 0;
                    addr_wait = 0;
                end else begin
                    data_wait = draw_delay();
                    addr_wait = draw_delay();
                end
            end else begin
                addr_wait--;
            end
        end
    end

    // trace monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (reset) begin
            assert (inst_sram_req !== 1'b1)
                else note_failure(T_RESET, "instruction request raised during reset");
            assert (debug_wb_rf_we === 4'b0)
                else note_failure(T_RESET, "trace write enable set during reset");
        end else begin
            if (debug_wb_rf_we != 4'b0) begin
                assert (first_data)
                    else note_failure(T_RESET, "trace write before the first fetch returned");
                check_write();
            end
            if (inst_sram_data_ok && !first_data) begin
                first_data = 1'b1;
                report_test(T_RESET);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d trace writes still missing",
                 cycle_count, expq.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed              = 32'h74a9e506;
        reset             = 1'b1;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = '0;
        pending           = 1'b0;
        pend_addr         = '0;
        data_wait         = 0;
        addr_wait         = draw_delay();
        first_data        = 1'b0;
        prog_len          = 0;
        test_name         = '{"reset", "imm_ops", "upper_imm", "rr_chain",
                              "r0_unknown", "random_delay"};
        for (int i = 0; i < NUM_TESTS; i++) begin
            remaining[i] = 0;
            err_count[i] = 0;
            reported[i]  = 1'b0;
        end
        for (int r = 0; r < 32; r++) begin
            gold[r] = '0;
        end
        load_program();
        assert (prog_len == PROG_LEN)
            else note_failure(T_ORDER, "program length differs from the program array");

        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        while (expq.size() != 0) begin
            @(posedge clk);
        end
        // quiet tail so stray writes from the zero padding still show up
        repeat (20) @(posedge clk);
        assert (i_dut.i_chk.fail_count == 0)
            else note_failure(T_ORDER, $sformatf("protocol checker saw %0d assertion failures",
                                                 i_dut.i_chk.fail_count));
        report_test(T_ORDER);

        passed = 0;
        failed = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (reported[i] && err_count[i] == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("tests: %0d run, %0d passed, %0d failed", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_unit.sv
rtl/inst_queue.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/exec_pipe.sv
rtl/core_top.sv
bench/core_chk.sv
bench/tb_core.sv

//--- Bender.yml
package:
  name: core_fetch_exec

sources:
  - rtl/isa_pkg.sv
  - rtl/pipe_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/inst_queue.sv
  - rtl/inst_decoder.sv
  - rtl/alu.sv
  - rtl/exec_pipe.sv
  - rtl/core_top.sv
  - target: test
    files:
      - bench/core_chk.sv
      - bench/tb_core.sv
